/* Bender.yml */
package:
  name: rv_decoder

sources:
  - hw/rv_decode_pkg.sv
  - hw/rv_op_classify.sv
  - hw/rv_imm_assemble.sv
  - hw/rv_decode_stage.sv
  - hw/rv_decoder_top.sv
  - target: test
    files:
      - testbench/tb_rv_decoder.sv

/* hw/rv_decode_pkg.sv */
// Decoder widths, opcode/format/operation enums and the decode result struct
package rv_decode_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int XLEN       = 32;  // Instruction and immediate width
    localparam int REG_ADDR_W = 5;   // x0..x31

    // ============================================================
    // Major opcodes, instr[6:0]
    // ============================================================
    typedef enum logic [6:0] {
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_SYSTEM   = 7'b1110011,
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_MISC_MEM = 7'b0001111
    } opcode_e;

    // ============================================================
    // Instruction formats
    // ============================================================
    typedef enum logic [3:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_CSR_REG,  // rs1 is a register
        FMT_CSR_IMM,  // rs1 field is a 5-bit uimm
        FMT_ENV       // ECALL, EBREAK, MRET, WFI
    } instr_format_e;

    // ============================================================
    // Decoded operations
    // ============================================================
    typedef enum logic [5:0] {
        // Branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // Loads and stores
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        // Register-immediate ALU
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        // Register-register ALU
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // Upper immediates, jumps, fence
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_FENCE,
        // Environment and privileged
        OP_ECALL, OP_EBREAK, OP_MRET, OP_WFI,
        // Zicsr
        OP_CSRRW, OP_CSRRS, OP_CSRRC,
        OP_CSRRWI, OP_CSRRSI, OP_CSRRCI,
        // M extension
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU
    } op_type_e;

    // ============================================================
    // Decode result
    // ============================================================
    typedef struct packed {
        op_type_e              op;
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        logic                  load_rs;  // rs1 and/or rs2 come from the regfile
    } decode_result_t;

endpackage

/* hw/rv_decode_stage.sv */
// Register field extraction, read flag, output register and ack/err strobes
`timescale 1ns/10ps

module rv_decode_stage (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           stb_i,
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    input  rv_decode_pkg::op_type_e        op_i,
    input  rv_decode_pkg::instr_format_e   fmt_i,
    input  logic                           illegal_i,
    input  logic [rv_decode_pkg::XLEN-1:0] imm_i,
    output rv_decode_pkg::decode_result_t  result_o,
    output logic                           ack_o,
    output logic                           err_o
);
    import rv_decode_pkg::*;

    decode_result_t result_d;

    // ============================================================
    // Field selection by format
    // ============================================================
    always_comb begin
        result_d.op  = op_i;
        result_d.imm = imm_i;

        result_d.rd = instr_i[11:7];
        if (fmt_i inside {FMT_S, FMT_B, FMT_ENV}) begin
            result_d.rd = '0;
        end

        result_d.rs1 = instr_i[19:15];  // uimm for CSR_IMM
        if (fmt_i inside {FMT_U, FMT_J, FMT_ENV}) begin
            result_d.rs1 = '0;
        end

        result_d.rs2 = '0;
        if (fmt_i inside {FMT_R, FMT_S, FMT_B}) begin
            result_d.rs2 = instr_i[24:20];
        end

        result_d.load_rs = fmt_i inside {FMT_R, FMT_I, FMT_S, FMT_B, FMT_CSR_REG};
    end

    // ============================================================
    // Output register
    // ============================================================
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            result_o <= '0;
            ack_o    <= 1'b0;
            err_o    <= 1'b0;
        end else begin
            ack_o <= stb_i & ~illegal_i;  // One-cycle strobes
            err_o <= stb_i & illegal_i;
            if (stb_i) begin
                result_o <= result_d;
            end
        end
    end

    a_ack_err_exclusive: assert property (@(posedge clk_i) disable iff (rst_i)
        !(ack_o && err_o));

    // Every response answers a strobe from the cycle before
    a_resp_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
        (ack_o || err_o) |-> $past(stb_i));

endmodule

/* hw/rv_decoder_top.sv */
// Top level of the one-cycle RV32IM/Zicsr instruction decoder
`timescale 1ns/10ps

module rv_decoder_top (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           stb_i,
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    output rv_decode_pkg::decode_result_t  result_o,
    output logic                           ack_o,
    output logic                           err_o
);
    import rv_decode_pkg::*;

    op_type_e        op;
    instr_format_e   fmt;
    logic            illegal;
    logic [XLEN-1:0] imm;

    rv_op_classify u_classify (
        .instr_i   (instr_i),
        .op_o      (op),
        .fmt_o     (fmt),
        .illegal_o (illegal)
    );

    rv_imm_assemble u_imm (
        .instr_i (instr_i),
        .fmt_i   (fmt),
        .imm_o   (imm)
    );

    rv_decode_stage u_stage (
        .clk_i     (clk_i),
        .rst_i     (rst_i),
        .stb_i     (stb_i),
        .instr_i   (instr_i),
        .op_i      (op),
        .fmt_i     (fmt),
        .illegal_i (illegal),
        .imm_i     (imm),
        .result_o  (result_o),
        .ack_o     (ack_o),
        .err_o     (err_o)
    );

endmodule

/* hw/rv_imm_assemble.sv */
// Sign-extended immediate assembly per instruction format
`timescale 1ns/10ps

module rv_imm_assemble (
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    input  rv_decode_pkg::instr_format_e   fmt_i,
    output logic [rv_decode_pkg::XLEN-1:0] imm_o
);
    import rv_decode_pkg::*;

    logic sign;  // Immediate sign is always instr[31]

    assign sign = instr_i[31];

    always_comb begin
        case (fmt_i)
            FMT_I: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:20]};
            end
            FMT_S: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[31:25], instr_i[11:7]};
            end
            FMT_B: begin
                imm_o = {{(XLEN-12){sign}}, instr_i[7], instr_i[30:25],
                         instr_i[11:8], 1'b0};
            end
            FMT_U: begin
                imm_o = {instr_i[31:12], 12'b0};
            end
            FMT_J: begin
                imm_o = {{(XLEN-20){sign}}, instr_i[19:12], instr_i[20],
                         instr_i[30:21], 1'b0};
            end
            FMT_CSR_REG, FMT_CSR_IMM: begin
                imm_o = {{(XLEN-12){1'b0}}, instr_i[31:20]};  // CSR address
            end
            default: begin
                imm_o = '0;  // R and ENV carry no immediate
            end
        endcase
    end

endmodule

/* hw/rv_op_classify.sv */
// Opcode, funct3 and funct7 classification into operation, format and illegal flag
`timescale 1ns/10ps

module rv_op_classify (
    input  logic [rv_decode_pkg::XLEN-1:0] instr_i,
    output rv_decode_pkg::op_type_e        op_o,
    output rv_decode_pkg::instr_format_e   fmt_o,
    output logic                           illegal_o
);
    import rv_decode_pkg::*;

    opcode_e     opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [11:0] funct12;     // SYSTEM env selector
    logic        bad_opcode;  // Major opcode not kept
    logic        bad_funct;   // Unlisted funct combination

    assign opcode  = opcode_e'(instr_i[6:0]);
    assign funct3  = instr_i[14:12];
    assign funct7  = instr_i[31:25];
    assign funct12 = instr_i[31:20];

    always_comb begin
        op_o       = OP_BEQ;
        fmt_o      = FMT_R;
        bad_opcode = 1'b0;
        bad_funct  = 1'b0;
        case (opcode)
            OPC_BRANCH: begin
                fmt_o = FMT_B;
                case (funct3)
                    3'b000:  op_o = OP_BEQ;
                    3'b001:  op_o = OP_BNE;
                    3'b100:  op_o = OP_BLT;
                    3'b101:  op_o = OP_BGE;
                    3'b110:  op_o = OP_BLTU;
                    3'b111:  op_o = OP_BGEU;
                    default: bad_funct = 1'b1;
                endcase
            end
            OPC_LOAD: begin
                fmt_o = FMT_I;
                case (funct3)
                    3'b000:  op_o = OP_LB;
                    3'b001:  op_o = OP_LH;
                    3'b010:  op_o = OP_LW;
                    3'b100:  op_o = OP_LBU;
                    3'b101:  op_o = OP_LHU;
                    default: bad_funct = 1'b1;
                endcase
            end
            OPC_STORE: begin
                fmt_o = FMT_S;
                case (funct3)
                    3'b000:  op_o = OP_SB;
                    3'b001:  op_o = OP_SH;
                    3'b010:  op_o = OP_SW;
                    default: bad_funct = 1'b1;
                endcase
            end
            OPC_OP_IMM: begin
                fmt_o = FMT_I;
                case (funct3)
                    3'b000: op_o = OP_ADDI;
                    3'b010: op_o = OP_SLTI;
                    3'b011: op_o = OP_SLTIU;
                    3'b100: op_o = OP_XORI;
                    3'b110: op_o = OP_ORI;
                    3'b111: op_o = OP_ANDI;
                    3'b001: begin
                        op_o      = OP_SLLI;
                        bad_funct = (funct7 != 7'b0000000);
                    end
                    default: begin  // 101, shift right
                        op_o      = funct7[5] ? OP_SRAI : OP_SRLI;
                        bad_funct = ({funct7[6], funct7[4:0]} != 6'b000000);
                    end
                endcase
            end
            OPC_OP: begin
                fmt_o = FMT_R;
                case (funct7)
                    7'b0000000: begin
                        case (funct3)
                            3'b000:  op_o = OP_ADD;
                            3'b001:  op_o = OP_SLL;
                            3'b010:  op_o = OP_SLT;
                            3'b011:  op_o = OP_SLTU;
                            3'b100:  op_o = OP_XOR;
                            3'b101:  op_o = OP_SRL;
                            3'b110:  op_o = OP_OR;
                            default: op_o = OP_AND;
                        endcase
                    end
                    7'b0100000: begin
                        case (funct3)
                            3'b000:  op_o = OP_SUB;
                            3'b101:  op_o = OP_SRA;
                            default: bad_funct = 1'b1;
                        endcase
                    end
                    7'b0000001: begin  // M extension
                        case (funct3)
                            3'b000:  op_o = OP_MUL;
                            3'b001:  op_o = OP_MULH;
                            3'b010:  op_o = OP_MULHSU;
                            3'b011:  op_o = OP_MULHU;
                            3'b100:  op_o = OP_DIV;
                            3'b101:  op_o = OP_DIVU;
                            3'b110:  op_o = OP_REM;
                            default: op_o = OP_REMU;
                        endcase
                    end
                    default: bad_funct = 1'b1;
                endcase
            end
            OPC_SYSTEM: begin
                case (funct3)
                    3'b000: begin
                        fmt_o = FMT_ENV;
                        case (funct12)
                            12'h000: op_o = OP_ECALL;
                            12'h001: op_o = OP_EBREAK;
                            12'h302: op_o = OP_MRET;
                            12'h105: op_o = OP_WFI;
                            default: bad_funct = 1'b1;
                        endcase
                    end
                    3'b001: begin
                        fmt_o = FMT_CSR_REG;
                        op_o  = OP_CSRRW;
                    end
                    3'b010: begin
                        fmt_o = FMT_CSR_REG;
                        op_o  = OP_CSRRS;
                    end
                    3'b011: begin
                        fmt_o = FMT_CSR_REG;
                        op_o  = OP_CSRRC;
                    end
                    3'b101: begin
                        fmt_o = FMT_CSR_IMM;
                        op_o  = OP_CSRRWI;
                    end
                    3'b110: begin
                        fmt_o = FMT_CSR_IMM;
                        op_o  = OP_CSRRSI;
                    end
                    3'b111: begin
                        fmt_o = FMT_CSR_IMM;
                        op_o  = OP_CSRRCI;
                    end
                    default: begin  // 100 is reserved
                        fmt_o     = FMT_ENV;
                        bad_funct = 1'b1;
                    end
                endcase
            end
            OPC_LUI: begin
                fmt_o = FMT_U;
                op_o  = OP_LUI;
            end
            OPC_AUIPC: begin
                fmt_o = FMT_U;
                op_o  = OP_AUIPC;
            end
            OPC_JAL: begin
                fmt_o = FMT_J;
                op_o  = OP_JAL;
            end
            OPC_JALR: begin
                fmt_o     = FMT_I;
                op_o      = OP_JALR;
                bad_funct = (funct3 != 3'b000);
            end
            OPC_MISC_MEM: begin
                fmt_o     = FMT_I;
                op_o      = OP_FENCE;
                bad_funct = (funct3 != 3'b000);  // No FENCE.I
            end
            default: bad_opcode = 1'b1;
        endcase
    end

    assign illegal_o = bad_opcode | bad_funct | (instr_i[1:0] != 2'b11);

    // An illegal R-type encoding must never fall back onto ADD
    always_comb begin
        a_no_illegal_add: assert final (!(illegal_o && fmt_o == FMT_R && op_o == OP_ADD))
            else $error("illegal R-type decoded as ADD");
    end

endmodule

/* testbench/tb_rv_decoder.sv */
// Random-stimulus testbench for the decoder top level with reference model and checks
`timescale 1ns/10ps

module tb_rv_decoder;
    import rv_decode_pkg::*;

    localparam int NUM_ITEMS    = 500;  // Random instructions per run
    localparam int RESP_TIMEOUT = 8;    // Cycles to wait for ack_o or err_o

    logic            clk_i = 1'b0;
    logic            rst_i;
    logic            stb_i;
    logic [XLEN-1:0] instr_i;
    decode_result_t  result_o;
    logic            ack_o;
    logic            err_o;

    integer seed;
    int     mismatch_count;
    int     failure_count;

    rv_decoder_top dut0 (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .stb_i    (stb_i),
        .instr_i  (instr_i),
        .result_o (result_o),
        .ack_o    (ack_o),
        .err_o    (err_o)
    );

    always #20 clk_i = ~clk_i;  // 40 ns period

    // ============================================================
    // Reference model
    // ============================================================
    task automatic predict_decode(input logic [XLEN-1:0] instr, output decode_result_t exp,
                                  output logic exp_err);
        instr_format_e fmt;
        op_type_e      op;
        logic [2:0]    f3;
        logic [6:0]    f7;
        f3      = instr[14:12];
        f7      = instr[31:25];
        fmt     = FMT_R;
        op      = OP_BEQ;
        exp_err = 1'b0;
        case (instr[6:0])
            7'b1100011: begin  // Branch
                fmt = FMT_B;
                case (f3)
                    3'd0: op = OP_BEQ;
                    3'd1: op = OP_BNE;
                    3'd4: op = OP_BLT;
                    3'd5: op = OP_BGE;
                    3'd6: op = OP_BLTU;
                    3'd7: op = OP_BGEU;
                    default: exp_err = 1'b1;
                endcase
            end
            7'b0000011: begin  // Load
                fmt = FMT_I;
                case (f3)
                    3'd0: op = OP_LB;
                    3'd1: op = OP_LH;
                    3'd2: op = OP_LW;
                    3'd4: op = OP_LBU;
                    3'd5: op = OP_LHU;
                    default: exp_err = 1'b1;
                endcase
            end
            7'b0100011: begin  // Store
                fmt = FMT_S;
                case (f3)
                    3'd0: op = OP_SB;
                    3'd1: op = OP_SH;
                    3'd2: op = OP_SW;
                    default: exp_err = 1'b1;
                endcase
            end
            7'b0010011: begin  // OP-IMM
                fmt = FMT_I;
                case (f3)
                    3'd0: op = OP_ADDI;
                    3'd2: op = OP_SLTI;
                    3'd3: op = OP_SLTIU;
                    3'd4: op = OP_XORI;
                    3'd6: op = OP_ORI;
                    3'd7: op = OP_ANDI;
                    3'd1: begin
                        op      = OP_SLLI;
                        exp_err = (f7 != 7'h00);
                    end
                    default: begin
                        op      = (f7 == 7'h20) ? OP_SRAI : OP_SRLI;
                        exp_err = (f7 != 7'h00) && (f7 != 7'h20);
                    end
                endcase
            end
            7'b0110011: begin  // OP, base and M
                fmt = FMT_R;
                case ({f7, f3})
                    {7'h00, 3'd0}: op = OP_ADD;
                    {7'h00, 3'd1}: op = OP_SLL;
                    {7'h00, 3'd2}: op = OP_SLT;
                    {7'h00, 3'd3}: op = OP_SLTU;
                    {7'h00, 3'd4}: op = OP_XOR;
                    {7'h00, 3'd5}: op = OP_SRL;
                    {7'h00, 3'd6}: op = OP_OR;
                    {7'h00, 3'd7}: op = OP_AND;
                    {7'h20, 3'd0}: op = OP_SUB;
                    {7'h20, 3'd5}: op = OP_SRA;
                    {7'h01, 3'd0}: op = OP_MUL;
                    {7'h01, 3'd1}: op = OP_MULH;
                    {7'h01, 3'd2}: op = OP_MULHSU;
                    {7'h01, 3'd3}: op = OP_MULHU;
                    {7'h01, 3'd4}: op = OP_DIV;
                    {7'h01, 3'd5}: op = OP_DIVU;
                    {7'h01, 3'd6}: op = OP_REM;
                    {7'h01, 3'd7}: op = OP_REMU;
                    default: exp_err = 1'b1;
                endcase
            end
            7'b1110011: begin  // SYSTEM
                case (f3)
                    3'd0: begin
                        fmt = FMT_ENV;
                        case (instr[31:20])
                            12'h000: op = OP_ECALL;
                            12'h001: op = OP_EBREAK;
                            12'h302: op = OP_MRET;
                            12'h105: op = OP_WFI;
                            default: exp_err = 1'b1;
                        endcase
                    end
                    3'd1: begin
                        fmt = FMT_CSR_REG;
                        op  = OP_CSRRW;
                    end
                    3'd2: begin
                        fmt = FMT_CSR_REG;
                        op  = OP_CSRRS;
                    end
                    3'd3: begin
                        fmt = FMT_CSR_REG;
                        op  = OP_CSRRC;
                    end
                    3'd5: begin
                        fmt = FMT_CSR_IMM;
                        op  = OP_CSRRWI;
                    end
                    3'd6: begin
                        fmt = FMT_CSR_IMM;
                        op  = OP_CSRRSI;
                    end
                    3'd7: begin
                        fmt = FMT_CSR_IMM;
                        op  = OP_CSRRCI;
                    end
                    default: exp_err = 1'b1;
                endcase
            end
            7'b0110111: begin
                fmt = FMT_U;
                op  = OP_LUI;
            end
            7'b0010111: begin
                fmt = FMT_U;
                op  = OP_AUIPC;
            end
            7'b1101111: begin
                fmt = FMT_J;
                op  = OP_JAL;
            end
            7'b1100111: begin
                fmt     = FMT_I;
                op      = OP_JALR;
                exp_err = (f3 != 3'd0);
            end
            7'b0001111: begin
                fmt     = FMT_I;
                op      = OP_FENCE;
                exp_err = (f3 != 3'd0);
            end
            default: exp_err = 1'b1;
        endcase
        if (instr[1:0] != 2'b11) begin
            exp_err = 1'b1;  // Compressed space is not decoded
        end

        exp.op = op;
        case (fmt)
            FMT_I: exp.imm = {{20{instr[31]}}, instr[31:20]};
            FMT_S: exp.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            FMT_B: exp.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            FMT_U: exp.imm = {instr[31:12], 12'h000};
            FMT_J: exp.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            FMT_CSR_REG, FMT_CSR_IMM: exp.imm = {20'h00000, instr[31:20]};
            default: exp.imm = '0;
        endcase
        exp.rd  = (fmt == FMT_S || fmt == FMT_B || fmt == FMT_ENV) ? 5'd0 : instr[11:7];
        exp.rs1 = (fmt == FMT_U || fmt == FMT_J || fmt == FMT_ENV) ? 5'd0 : instr[19:15];
        exp.rs2 = (fmt == FMT_R || fmt == FMT_S || fmt == FMT_B) ? instr[24:20] : 5'd0;
        exp.load_rs = (fmt == FMT_R || fmt == FMT_I || fmt == FMT_S || fmt == FMT_B ||
                       fmt == FMT_CSR_REG);
    endtask

    // ============================================================
    // Stimulus
    // ============================================================
    task automatic pick_funct7(output logic [6:0] f7);
        int sel;
        sel = $unsigned($random(seed)) % 4;
        case (sel)
            0: f7 = 7'h00;
            1: f7 = 7'h20;
            2: f7 = 7'h01;
            default: f7 = 7'($random(seed));  // Mostly illegal
        endcase
    endtask

    task automatic make_instr(output logic [XLEN-1:0] instr, output string name);
        int         kind;
        int         sel;
        logic [6:0] f7;
        instr = $random(seed);  // Random funct and register bits
        kind  = $unsigned($random(seed)) % 16;
        case (kind)
            0, 1: begin
                name = "r_type";
                instr[6:0] = 7'b0110011;
                pick_funct7(f7);
                instr[31:25] = f7;
            end
            2: begin
                name = "op_imm";
                instr[6:0] = 7'b0010011;
                if (instr[13:12] == 2'b01) begin  // Shifts
                    pick_funct7(f7);
                    instr[31:25] = f7;
                end
            end
            3: begin
                name = "load";
                instr[6:0] = 7'b0000011;
            end
            4: begin
                name = "store";
                instr[6:0] = 7'b0100011;
            end
            5: begin
                name = "branch";
                instr[6:0] = 7'b1100011;
            end
            6: begin
                name = "u_type";
                instr[6:0] = instr[5] ? 7'b0110111 : 7'b0010111;
            end
            7: begin
                name = "jal";
                instr[6:0] = 7'b1101111;
            end
            8: begin
                name = "jalr";
                instr[6:0] = 7'b1100111;
                instr[14:12] = instr[13] ? 3'b000 : instr[14:12];
            end
            9: begin
                name = "fence";
                instr[6:0] = 7'b0001111;
                instr[14:12] = instr[13] ? 3'b000 : instr[14:12];
            end
            10: begin
                name = "csr";
                instr[6:0] = 7'b1110011;
                if (instr[14:12] == 3'b000) begin
                    instr[14:12] = 3'b001;
                end
            end
            11: begin
                name = "env";
                instr[6:0]   = 7'b1110011;
                instr[14:12] = 3'b000;
                sel = $unsigned($random(seed)) % 5;
                case (sel)
                    0: instr[31:20] = 12'h000;
                    1: instr[31:20] = 12'h001;
                    2: instr[31:20] = 12'h302;
                    3: instr[31:20] = 12'h105;
                    default: ;  // Keep random funct12
                endcase
            end
            12: begin
                name = "bad_opcode";
                instr[1:0] = 2'b11;
            end
            13: begin
                name = "bad_low_bits";
                if (instr[1:0] == 2'b11) begin
                    instr[1:0] = 2'b10;
                end
            end
            default: name = "random";
        endcase
    endtask

    // ============================================================
    // Drive and check
    // ============================================================
    task automatic check_idle(input string what);
        @(negedge clk_i);
        assert (!ack_o && !err_o)
        else begin
            $display("ack_o or err_o high with no strobe pending (%s)", what);
            failure_count++;
        end
    endtask

    // Called on a falling edge; returns on the falling edge of the response
    task automatic run_one(input logic [XLEN-1:0] instr, input string name);
        decode_result_t exp;
        logic           exp_err;
        int             cycles;
        stb_i   = 1'b1;
        instr_i = instr;
        predict_decode(instr, exp, exp_err);
        @(negedge clk_i);
        stb_i  = 1'b0;  // Caller may raise it again at this edge
        cycles = 1;
        while (!(ack_o || err_o) && cycles < RESP_TIMEOUT) begin
            @(negedge clk_i);
            cycles++;
        end
        assert (ack_o || err_o)
        else begin
            $display("no response to %s strobe within %0d cycles", name, RESP_TIMEOUT);
            failure_count++;
        end
        if (ack_o || err_o) begin
            assert (cycles == 1)
            else begin
                $display("response to %s came after %0d cycles instead of 1", name, cycles);
                failure_count++;
            end
            assert (!(ack_o && err_o))
            else begin
                $display("ack_o and err_o high together for %s", name);
                failure_count++;
            end
            assert (err_o == exp_err)
            else begin
                $display("mismatch %s err_o (instr %h): expected %0b actual %0b",
                         name, instr, exp_err, err_o);
                mismatch_count++;
            end
            if (ack_o && !exp_err) begin
                assert (result_o == exp)
                else begin
                    $display("mismatch %s result (instr %h): expected %h (%s) actual %h (%s)",
                             name, instr, exp, exp.op.name(), result_o, result_o.op.name());
                    mismatch_count++;
                end
            end
        end
    endtask

    initial begin
        logic [XLEN-1:0] instr;
        string           name;
        seed           = 98;
        mismatch_count = 0;
        failure_count  = 0;
        rst_i          = 1'b1;
        stb_i          = 1'b0;
        instr_i        = '0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        assert (result_o == '0)
        else begin
            $display("mismatch after_reset result_o: expected 0 actual %h", result_o);
            mismatch_count++;
        end

        repeat (4) check_idle("after reset");

        for (int i = 0; i < NUM_ITEMS; i++) begin
            make_instr(instr, name);
            run_one(instr, name);
            if ($unsigned($random(seed)) % 3 == 0) begin
                check_idle(name);  // Response must be a single-cycle pulse
            end
        end
        check_idle("end of run");

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* vlog.f */
hw/rv_decode_pkg.sv
hw/rv_op_classify.sv
hw/rv_imm_assemble.sv
hw/rv_decode_stage.sv
hw/rv_decoder_top.sv
testbench/tb_rv_decoder.sv
